// ==== sources.f ====
mips_pkg.sv
ctrl_if.sv
control_unit.sv
alu.sv
register_file.sv
data_memory.sv
instr_memory.sv
mips_top.sv
tb_clock.sv
mips_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run with Verilator. The exit status is the test result.
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal --top-module mips_tb \
	-f sources.f -o mips_tb_sim
./obj_dir/mips_tb_sim

// ==== mips_tb.sv ====
`timescale 1ns/100ps

module mips_tb;
	import mips_pkg::*;

	logic       clk, arst_n;
	logic       run, imem_we, mem_write; // Run stays low while the program is loaded.
	imem_addr_t imem_addr;
	word_t      imem_wdata, pc, mem_addr, mem_wdata;

	word_t       prog [IMEM_DEPTH];          // Assembled program.
	word_t       next_pc [IMEM_DEPTH];       // Model pc after each instruction.
	word_t       exp_data [DMEM_DEPTH];      // Expected store data. Store k goes to byte 4*k.
	word_t       mdl [32] = '{default: '0}; // Model register file.
	int          n_instr = 0;
	int          n_exp = 0;
	int          st_idx = 0;                 // Stores seen on the bus.
	int          cycles = 0;
	word_t       exp_pc = '0;                // Model pc.
	logic [31:0] lfsr_state = 32'd14;

	tb_clock tb_clock_i (.*);
	mips_top mips_top_i (.*);

	// Galois LFSR stepped once per bit taken.
	function automatic word_t rand_bits(input int n);
		word_t v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Reference results. Immediates reuse the matching funct code.
	function automatic word_t golden(input funct_t fn, input word_t a, input word_t b);
		case (fn)
			FN_ADD:  return a + b;
			FN_SUB:  return a - b;
			FN_AND:  return a & b;
			FN_OR:   return a | b;
			FN_XOR:  return a ^ b;
			FN_SLT:  return {31'd0, $signed(a) < $signed(b)}; // Signed compare.
			FN_MUL:  return a * b; // Low word of the product.
			default: return '0;
		endcase
	endfunction

	task automatic stop_with(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1, "simulation aborted");
	endtask

	// Skip counts the words jumped over.
	task automatic emit_instr(input word_t instr, input int skip);
		prog[n_instr] = instr;
		next_pc[n_instr] = word_t'((n_instr + 1 + skip) * 4);
		n_instr++;
	endtask

	task automatic store_reg(input reg_addr_t rt);
		exp_data[n_exp] = mdl[rt];
		emit_instr({OP_SW, 5'd0, rt, 16'(n_exp * 4)}, 0); // Base is r0.
		n_exp++;
	endtask

	// Random sources and immediate with the result stored right away.
	task automatic alu_then_store(input opcode_t op, input funct_t fn);
		reg_addr_t rs, rt, rd;
		word_t     imm;
		rs = reg_addr_t'(rand_bits(5));
		rt = reg_addr_t'(rand_bits(5));
		rd = reg_addr_t'(1 + rand_bits(5) % 31); // Never r0.
		imm = rand_bits(16);
		imm = {{16{imm[15]}}, imm[15:0]}; // Sign extended.
		if (op == OP_RTYPE || op == OP_SPECIAL2)
		begin
			emit_instr({op, rs, rt, rd, 5'd0, fn}, 0);
			mdl[rd] = golden(fn, mdl[rs], mdl[rt]);
		end
		else
		begin
			emit_instr({op, rs, rd, imm[15:0]}, 0);
			mdl[rd] = golden(fn, mdl[rs], imm);
		end
		store_reg(rd);
	endtask

	initial
	begin
		reg_addr_t   ra, rb;
		word_t       junk;
		logic [15:0] fill;
		run = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		for (int k = 0; k < 2; k++)
		begin
			alu_then_store(OP_ADDI, FN_ADD);
			alu_then_store(OP_ANDI, FN_AND);
			alu_then_store(OP_ORI, FN_OR);
			alu_then_store(OP_XORI, FN_XOR);
		end
		alu_then_store(OP_RTYPE, FN_ADD);
		alu_then_store(OP_RTYPE, FN_SUB);
		alu_then_store(OP_RTYPE, FN_AND);
		alu_then_store(OP_RTYPE, FN_OR);
		alu_then_store(OP_RTYPE, FN_XOR);
		alu_then_store(OP_RTYPE, FN_SLT);
		alu_then_store(OP_SPECIAL2, FN_MUL);
		emit_instr({OP_ADDI, 5'd0, 5'd0, 16'h1234}, 0); // Dropped write to r0.
		store_reg(5'd0);
		ra = reg_addr_t'(1 + rand_bits(5) % 31);
		rb = (ra == 5'd31) ? 5'd30 : ra + 5'd1;
		fill = ~mdl[rb][15:0];
		emit_instr({OP_ADDI, 5'd0, ra, fill}, 0); // Gives ra a value that rb does not hold.
		mdl[ra] = {{16{fill[15]}}, fill};
		store_reg(ra); // Stored, loaded into rb, stored again.
		emit_instr({OP_LW, 5'd0, rb, 16'((n_exp - 1) * 4)}, 0);
		mdl[rb] = mdl[ra];
		store_reg(rb);
		emit_instr({OP_J, 26'(n_instr + 2)}, 1); // Jumps over the next store.
		emit_instr({OP_SW, 5'd0, ra, 16'd252}, 0);
		emit_instr({OP_BEQ, 5'd0, 5'd0, 16'd1}, 1); // Always taken.
		emit_instr({OP_SW, 5'd0, rb, 16'd252}, 0);
		emit_instr({OP_ADDI, 5'd0, 5'd31, 16'h0055}, 0);
		mdl[31] = 32'h0000_0055;
		emit_instr({OP_BEQ, 5'd31, 5'd0, 16'd1}, 0); // Not taken because r31 is nonzero.
		store_reg(5'd31);
		junk = rand_bits(26);
		emit_instr({6'b111111, junk[25:0]}, 0); // Unknown opcode.
		store_reg(ra);

		@(posedge arst_n);
		for (int i = 0; i < n_instr; i++)
		begin
			@(negedge clk);
			imem_we = 1'b1;
			imem_addr = imem_addr_t'(i);
			imem_wdata = prog[i];
		end
		@(negedge clk);
		imem_we = 1'b0;
		run = 1'b1;
		wait (st_idx == n_exp);
		@(negedge clk);
		$display("Test passed");
		$finish;
	end

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			exp_pc <= '0;
		else if (run)
			exp_pc <= next_pc[exp_pc[7:2]]; // Planned control flow.
	end

	always @(posedge clk)
	begin
		if (mem_write)
			st_idx <= st_idx + 1;
		cycles <= cycles + 1;
		// Load, reset, execution and some slack.
		if (cycles >= n_instr + 10 + n_instr + 20)
			stop_with($sformatf("Timeout, the program did not finish in %0d cycles", cycles));
	end

	// Stores come only while running, in program order, with the model's data.
	assert property (@(posedge clk) mem_write |-> run && (st_idx < n_exp)
		&& (mem_addr == word_t'(st_idx * 4)) && (mem_wdata == exp_data[st_idx]))
		else stop_with($sformatf("ERR %0t: store %h to %h, expected %h to %h", $time,
			mem_wdata, mem_addr, exp_data[st_idx], word_t'(st_idx * 4)));

	// Pc follows the model through reset, load and execution.
	assert property (@(posedge clk) pc == exp_pc)
		else stop_with($sformatf("ERR %0t: pc %h, expected %h", $time, pc, exp_pc));

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk; // 8 ns period.
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk); // Ten cycles in reset.
		@(negedge clk);
		arst_n = 1'b1; // Released away from the rising edge.
	end

endmodule

// ==== mips_top.sv ====
`timescale 1ns/100ps

module mips_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 run,
	input  logic                 imem_we,
	input  mips_pkg::imem_addr_t imem_addr,
	input  mips_pkg::word_t      imem_wdata,
	output mips_pkg::word_t      pc,
	output logic                 mem_write,
	output mips_pkg::word_t      mem_addr,
	output mips_pkg::word_t      mem_wdata
);
	import mips_pkg::*;

	ctrl_if ctrl_bus (); // Decoder outputs.

	word_t     instr;         // Current instruction.
	opcode_t   opcode;        // Bits 31:26.
	reg_addr_t rs;            // First source register.
	reg_addr_t rt;            // Second source or I-type destination.
	reg_addr_t rd;            // R-type destination.
	reg_addr_t wa;            // Selected destination.
	funct_t    funct;         // Bits 5:0.
	word_t     imm_ext;       // Sign-extended immediate.
	word_t     rd_a;          // Register port A.
	word_t     rd_b;          // Register port B.
	word_t     alu_b;         // Second ALU operand.
	word_t     alu_result;
	logic      alu_zero;      // Equal compare for BEQ.
	word_t     mem_rdata;     // Load data.
	word_t     wb_data;       // Register write-back value.
	logic      reg_we;        // Register write, gated by run.
	word_t     pc_plus4;
	word_t     jump_target;
	word_t     branch_target;
	word_t     pc_next;

	assign opcode  = instr[31:26];
	assign rs      = instr[25:21];
	assign rt      = instr[20:16];
	assign rd      = instr[15:11];
	assign funct   = instr[5:0];
	assign imm_ext = {{16{instr[15]}}, instr[15:0]}; // Sign extension.

	// Next pc.
	assign pc_plus4      = pc + 32'd4;
	assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00}; // Region plus index.
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00}; // Word offset.

	always_comb
	begin
		if (ctrl_bus.jump)
			pc_next = jump_target;
		else if (ctrl_bus.branch && alu_zero)
			pc_next = branch_target; // Taken BEQ.
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pc <= '0;
		else if (run)
			pc <= pc_next; // One instruction retires per edge.
	end

	// Datapath muxes.
	assign wa      = ctrl_bus.reg_dst ? rd : rt;
	assign alu_b   = ctrl_bus.alu_src ? imm_ext : rd_b;
	assign wb_data = ctrl_bus.mem_to_reg ? mem_rdata : alu_result;

	// Side effects only while running.
	assign reg_we    = ctrl_bus.reg_write && run;
	assign mem_write = ctrl_bus.mem_write && run;
	assign mem_addr  = alu_result; // Base plus offset.
	assign mem_wdata = rd_b;       // Store data from rt.

	instr_memory instr_memory_i (
		.clk   (clk),
		.we    (imem_we && !run), // Loading only while halted.
		.waddr (imem_addr),
		.wdata (imem_wdata),
		.pc    (pc),
		.instr (instr)
	);

	control_unit control_unit_i (
		.opcode (opcode),
		.c      (ctrl_bus.ctrl)
	);

	register_file register_file_i (
		.clk    (clk),
		.arst_n (arst_n),
		.we     (reg_we),
		.ra     (rs),
		.rb     (rt),
		.wa     (wa),
		.wd     (wb_data),
		.rd_a   (rd_a),
		.rd_b   (rd_b)
	);

	alu alu_i (
		.alu_op   (ctrl_bus.alu_op),
		.funct    (funct),
		.special2 (opcode == OP_SPECIAL2), // MUL decoding.
		.a        (rd_a),
		.b        (alu_b),
		.result   (alu_result),
		.zero     (alu_zero)
	);

	data_memory data_memory_i (
		.clk   (clk),
		.we    (mem_write),
		.addr  (alu_result),
		.wdata (rd_b),
		.rdata (mem_rdata)
	);

	// Jump and branch targets keep the pc on word boundaries.
	assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
		else $error("mips_top: pc %h not word aligned", pc);

endmodule

// ==== instr_memory.sv ====
`timescale 1ns/100ps

module instr_memory (
	input  logic                 clk,
	input  logic                 we,
	input  mips_pkg::imem_addr_t waddr,
	input  mips_pkg::word_t      wdata,
	input  mips_pkg::word_t      pc,
	output mips_pkg::word_t      instr
);
	import mips_pkg::*;

	word_t mem [IMEM_DEPTH]; // Program storage.

	assign instr = mem[pc[7:2]]; // Fetch by word index.

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata; // Program load port.
	end

endmodule

// ==== data_memory.sv ====
`timescale 1ns/100ps

module data_memory (
	input  logic            clk,
	input  logic            we,
	input  mips_pkg::word_t addr,
	input  mips_pkg::word_t wdata,
	output mips_pkg::word_t rdata
);
	import mips_pkg::*;

	word_t mem [DMEM_DEPTH]; // Data storage.

	assign rdata = mem[addr[7:2]]; // Same-cycle load data.

	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr[7:2]] <= wdata; // Store completes at the closing edge.
	end

	// Stores are whole, aligned words inside the array.
	assert property (@(posedge clk)
		we |-> (addr[1:0] == 2'b00) && (addr < word_t'(DMEM_DEPTH * 4)))
		else $error("data_memory: bad store address %h", addr);

endmodule

// ==== register_file.sv ====
`timescale 1ns/100ps

module register_file (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                we,
	input  mips_pkg::reg_addr_t ra,
	input  mips_pkg::reg_addr_t rb,
	input  mips_pkg::reg_addr_t wa,
	input  mips_pkg::word_t     wd,
	output mips_pkg::word_t     rd_a,
	output mips_pkg::word_t     rd_b
);
	import mips_pkg::*;

	word_t regs [32]; // Architectural registers.

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0; // All registers start at zero.
		end
		else if (we && (wa != '0))
		begin
			regs[wa] <= wd; // Register 0 is never written.
		end
	end

	assign rd_a = regs[ra]; // Port A, feeds the ALU.
	assign rd_b = regs[rb]; // Port B, ALU or store data.

	// Register 0 must still read zero after any sequence of writes.
	assert property (@(posedge clk) disable iff (!arst_n) (ra == '0) |-> (rd_a == '0))
		else $error("register_file: register 0 reads nonzero");

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu (
	input  mips_pkg::alu_op_t alu_op,
	input  mips_pkg::funct_t  funct,
	input  logic              special2,
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	output mips_pkg::word_t   result,
	output logic              zero
);
	import mips_pkg::*;

	word_t funct_result; // Result of the funct-decoded operation.

	always_comb
	begin
		funct_result = '0; // Unknown funct codes give zero.
		if (special2)
		begin
			if (funct == FN_MUL)
				funct_result = a * b; // Low half of the product.
		end
		else
		begin
			case (funct)
				FN_ADD:
					funct_result = a + b;
				FN_SUB:
					funct_result = a - b;
				FN_AND:
					funct_result = a & b;
				FN_OR:
					funct_result = a | b;
				FN_XOR:
					funct_result = a ^ b;
				FN_SLT:
					funct_result = word_t'($signed(a) < $signed(b)); // Signed compare.
				default:
					funct_result = '0;
			endcase
		end
	end

	always_comb
	begin
		case (alu_op)
			ALU_FUNCT:
				result = funct_result; // R-type and SPECIAL2.
			ALU_ADD:
				result = a + b; // Immediates and addresses.
			ALU_SUB:
				result = a - b; // BEQ compare.
			ALU_AND:
				result = a & b;
			ALU_OR:
				result = a | b;
			ALU_XOR:
				result = a ^ b;
			default:
				result = '0;
		endcase
	end

	assign zero = (result == '0); // Drives the BEQ decision.

endmodule

// ==== control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
	input mips_pkg::opcode_t opcode,
	ctrl_if.ctrl             c
);
	import mips_pkg::*;

	always_comb
	begin
		// Everything off, unknown opcodes fall through as no-operations.
		c.reg_dst    = 1'b0;
		c.jump       = 1'b0;
		c.branch     = 1'b0;
		c.mem_to_reg = 1'b0;
		c.alu_op     = ALU_FUNCT;
		c.mem_write  = 1'b0;
		c.alu_src    = 1'b0;
		c.reg_write  = 1'b0;

		case (opcode)
			OP_ADDI:
			begin
				c.reg_write = 1'b1; // Result goes to rt.
				c.alu_op    = ALU_ADD;
				c.alu_src   = 1'b1; // Immediate operand.
			end
			OP_ANDI:
			begin
				c.reg_write = 1'b1;
				c.alu_op    = ALU_AND; // Immediate is sign extended, not zero extended.
				c.alu_src   = 1'b1;
			end
			OP_ORI:
			begin
				c.reg_write = 1'b1;
				c.alu_op    = ALU_OR;
				c.alu_src   = 1'b1;
			end
			OP_XORI:
			begin
				c.reg_write = 1'b1;
				c.alu_op    = ALU_XOR;
				c.alu_src   = 1'b1;
			end
			OP_RTYPE, OP_SPECIAL2:
			begin
				c.reg_write = 1'b1;
				c.reg_dst   = 1'b1; // Three-register form, write rd.
				c.alu_op    = ALU_FUNCT; // ALU looks at funct.
			end
			OP_SW:
			begin
				c.mem_write = 1'b1;
				c.alu_op    = ALU_ADD; // Base plus offset.
				c.alu_src   = 1'b1;
			end
			OP_LW:
			begin
				c.reg_write  = 1'b1;
				c.mem_to_reg = 1'b1; // Load data to rt.
				c.alu_op     = ALU_ADD;
				c.alu_src    = 1'b1;
			end
			OP_J:
				c.jump = 1'b1; // No ALU, no writes.
			OP_BEQ:
			begin
				c.branch = 1'b1;
				c.alu_op = ALU_SUB; // Zero result means equal.
			end
			default:
				c.jump = 1'b0;
		endcase
	end

	// At most one of the pc and memory side effects per instruction.
	always_comb
	begin
		assert ($onehot0({c.jump, c.branch, c.mem_write}))
			else $error("control_unit: jump, branch and mem_write overlap");
	end

endmodule

// ==== ctrl_if.sv ====
`timescale 1ns/100ps

interface ctrl_if;
	import mips_pkg::*;

	logic    reg_dst;    // Write to rd when set, to rt otherwise.
	logic    jump;       // Take the J target.
	logic    branch;     // BEQ, taken when the ALU result is zero.
	logic    mem_to_reg; // Write back load data instead of the ALU result.
	alu_op_t alu_op;     // Operation class for the ALU.
	logic    mem_write;  // Store to data memory.
	logic    alu_src;    // Second ALU operand is the immediate.
	logic    reg_write;  // Write the register file.

	// Decoder side.
	modport ctrl (
		output reg_dst,
		output jump,
		output branch,
		output mem_to_reg,
		output alu_op,
		output mem_write,
		output alu_src,
		output reg_write
	);

	// Datapath side.
	modport dp (
		input reg_dst,
		input jump,
		input branch,
		input mem_to_reg,
		input alu_op,
		input mem_write,
		input alu_src,
		input reg_write
	);

endinterface

// ==== mips_pkg.sv ====
package mips_pkg;

	typedef logic [31:0] word_t;      // Data word or byte address.
	typedef logic [4:0]  reg_addr_t;  // Register file index.
	typedef logic [5:0]  opcode_t;    // Instruction bits 31:26.
	typedef logic [5:0]  funct_t;     // R-type funct field, instruction bits 5:0.
	typedef logic [5:0]  imem_addr_t; // Word index into the instruction memory.

	// Operation class picked by the decoder, the ALU resolves ALU_FUNCT itself.
	typedef enum logic [3:0] {
		ALU_FUNCT = 4'd0, // Operation decided by the funct field.
		ALU_ADD   = 4'd1, // Addition, also used for load and store addresses.
		ALU_SUB   = 4'd2, // Subtraction, used by BEQ for the compare.
		ALU_AND   = 4'd3, // Bitwise and.
		ALU_OR    = 4'd4, // Bitwise or.
		ALU_XOR   = 4'd5  // Bitwise exclusive or.
	} alu_op_t;

	// Primary opcodes.
	localparam opcode_t OP_RTYPE    = 6'b000000; // Register-register arithmetic.
	localparam opcode_t OP_J        = 6'b000010; // Absolute jump within the 256 MB region.
	localparam opcode_t OP_BEQ      = 6'b000100; // Branch when both registers are equal.
	localparam opcode_t OP_ADDI     = 6'b001000; // Add sign-extended immediate.
	localparam opcode_t OP_ANDI     = 6'b001100; // And with sign-extended immediate.
	localparam opcode_t OP_ORI      = 6'b001101; // Or with sign-extended immediate.
	localparam opcode_t OP_XORI     = 6'b001110; // Xor with sign-extended immediate.
	localparam opcode_t OP_SPECIAL2 = 6'b011100; // MUL lives here.
	localparam opcode_t OP_LW       = 6'b100011; // Load word.
	localparam opcode_t OP_SW       = 6'b101011; // Store word.

	// Funct codes for R-type.
	localparam funct_t FN_ADD = 6'b100000; // rd = rs + rt.
	localparam funct_t FN_SUB = 6'b100010; // rd = rs - rt.
	localparam funct_t FN_AND = 6'b100100; // rd = rs & rt.
	localparam funct_t FN_OR  = 6'b100101; // rd = rs | rt.
	localparam funct_t FN_XOR = 6'b100110; // rd = rs ^ rt.
	localparam funct_t FN_SLT = 6'b101010; // Signed compare, rd = 1 when rs < rt.

	// Funct code under SPECIAL2.
	localparam funct_t FN_MUL = 6'b000010; // Low 32 bits of rs * rt.

	// Memory sizes in words.
	localparam int IMEM_DEPTH = 64; // Program space, pc bits 7:2.
	localparam int DMEM_DEPTH = 64; // Data space, address bits 7:2.

endpackage
